// File: rtl/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath width and register file address width
`define DECODE_XLEN    32
`define DECODE_RADDR_W 5

// PC seen in IF/ID out of reset, same as the cleared payload
`define DECODE_RESET_PC 32'h0000_0000

`endif

// File: rtl/isa_pkg.sv
`include "decode_settings.svh"

package isa_pkg;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, // R-type, real operation in funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function code of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_MFHI    = 6'h10,
        FN_MTHI    = 6'h11,
        FN_MFLO    = 6'h12,
        FN_MTLO    = 6'h13,
        FN_MULT    = 6'h18,
        FN_MULTU   = 6'h19,
        FN_DIV     = 6'h1a,
        FN_DIVU    = 6'h1b,
        FN_ADDU    = 6'h21
    } funct_e;

    // R-type view of an instruction word
    // Immediate is [15:0] and jump target is [25:0] of the same word
    typedef struct packed {
        opcode_e                    opcode;
        logic [`DECODE_RADDR_W-1:0] rs;
        logic [`DECODE_RADDR_W-1:0] rt;
        logic [`DECODE_RADDR_W-1:0] rd;
        logic [4:0]                 shamt;
        funct_e                     funct;
    } fields_t;

    // IF/ID payload
    typedef struct packed {
        logic                    valid;
        logic [`DECODE_XLEN-1:0] pc;
        logic [`DECODE_XLEN-1:0] instr;
    } fetch_t;

endpackage

// File: rtl/ctrl_pkg.sv
`include "decode_settings.svh"

package ctrl_pkg;

    // Encodings are chosen so that an all-zero bundle is a no-op

    typedef enum logic [1:0] {
        OPD_USE_NONE, OPD_USE_RS, OPD_USE_RT, OPD_USE_RS_RT
    } opd_use_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_OR, ALU_SHIFT_LEFT, ALU_PASS_B, ALU_NCARE
    } alu_op_e;

    typedef enum logic {ALU_B_REG, ALU_B_IMM} alu_b_e;

    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R31} dest_e;

    typedef enum logic [2:0] {
        REG_SRC_ALU, REG_SRC_MEM, REG_SRC_HI, REG_SRC_LO, REG_SRC_PC8
    } reg_src_e;

    typedef enum logic {HILO_SRC_RS, HILO_SRC_MULDIV} hilo_src_e;

    typedef enum logic [2:0] {
        MULDIV_NCARE = 3'd0, // Nothing issued to the multiplier
        MULDIV_MULT  = 3'd1,
        MULDIV_MULTU = 3'd2,
        MULDIV_DIV   = 3'd3,
        MULDIV_DIVU  = 3'd4
    } muldiv_e;

    typedef enum logic [2:0] {
        PC_SRC_SEQ, PC_SRC_BRANCH_EQ, PC_SRC_BRANCH_NE,
        PC_SRC_JUMP, PC_SRC_JUMP_REG, PC_SRC_EXCEPTION
    } pc_src_e;

    typedef enum logic [1:0] {EXC_NONE, EXC_SYSCALL, EXC_RESERVED} exc_e;

    typedef enum logic [1:0] {IMM_EXT_SIGN, IMM_EXT_ZERO, IMM_EXT_UPPER} imm_ext_e;

    typedef struct packed {
        opd_use_e  opd_use;      // Source registers read
        alu_op_e   alu_op;
        alu_b_e    alu_b;
        dest_e     dest;
        logic      write_reg;
        reg_src_e  reg_src;      // Write-back data source
        hilo_src_e hilo_src;
        logic      write_hi;
        logic      write_lo;
        muldiv_e   muldiv_funct;
        pc_src_e   pc_src;
        exc_e      exc_chk;
        logic      mem_read;
        logic      mem_write;
        imm_ext_e  imm_ext;
    } control_t;

    // ID/EX payload
    typedef struct packed {
        logic                       valid;
        logic [`DECODE_XLEN-1:0]    pc;
        control_t                   ctl;
        logic [`DECODE_RADDR_W-1:0] rs;
        logic [`DECODE_RADDR_W-1:0] rt;
        logic [`DECODE_RADDR_W-1:0] rd;
        logic [4:0]                 shamt;
        logic [`DECODE_XLEN-1:0]    imm;        // Already extended
        logic [25:0]                jump_index;
    } decoded_t;

    // No writes, no memory access, sequential PC, no exception
    function automatic control_t default_control();
        control_t ctl;
        ctl.opd_use      = OPD_USE_NONE;
        ctl.alu_op       = ALU_ADD;
        ctl.alu_b        = ALU_B_REG;
        ctl.dest         = DEST_RD;
        ctl.write_reg    = 1'b0;
        ctl.reg_src      = REG_SRC_ALU;
        ctl.hilo_src     = HILO_SRC_RS;
        ctl.write_hi     = 1'b0;
        ctl.write_lo     = 1'b0;
        ctl.muldiv_funct = MULDIV_NCARE;
        ctl.pc_src       = PC_SRC_SEQ;
        ctl.exc_chk      = EXC_NONE;
        ctl.mem_read     = 1'b0;
        ctl.mem_write    = 1'b0;
        ctl.imm_ext      = IMM_EXT_SIGN;
        return ctl;
    endfunction

endpackage

// File: rtl/rtype_decoder.sv
`timescale 1ns/1ps

module rtype_decoder (
    input  isa_pkg::funct_e    funct,
    output ctrl_pkg::control_t ctl
);

    // R-type write to rd, ALU operands come from registers
    function automatic ctrl_pkg::control_t write_rd(
        input ctrl_pkg::control_t base,
        input ctrl_pkg::reg_src_e src
    );
        ctrl_pkg::control_t c;
        c           = base;
        c.dest      = ctrl_pkg::DEST_RD;
        c.write_reg = 1'b1;
        c.reg_src   = src;
        return c;
    endfunction

    always_comb begin
        ctl = ctrl_pkg::default_control();

        case (funct)
            isa_pkg::FN_ADDU: begin
                ctl         = write_rd(ctl, ctrl_pkg::REG_SRC_ALU);
                ctl.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                ctl.alu_op  = ctrl_pkg::ALU_ADD;
                ctl.alu_b   = ctrl_pkg::ALU_B_REG;
            end

            isa_pkg::FN_SLL: begin
                ctl         = write_rd(ctl, ctrl_pkg::REG_SRC_ALU);
                ctl.opd_use = ctrl_pkg::OPD_USE_RT; // Shift amount comes from shamt
                ctl.alu_op  = ctrl_pkg::ALU_SHIFT_LEFT;
            end

            isa_pkg::FN_JR: begin
                ctl.opd_use = ctrl_pkg::OPD_USE_RS;
                ctl.pc_src  = ctrl_pkg::PC_SRC_JUMP_REG;
            end

            isa_pkg::FN_MFHI: ctl = write_rd(ctl, ctrl_pkg::REG_SRC_HI);
            isa_pkg::FN_MFLO: ctl = write_rd(ctl, ctrl_pkg::REG_SRC_LO);

            isa_pkg::FN_MTHI: begin
                ctl.opd_use  = ctrl_pkg::OPD_USE_RS;
                ctl.hilo_src = ctrl_pkg::HILO_SRC_RS;
                ctl.write_hi = 1'b1;
            end

            isa_pkg::FN_MTLO: begin
                ctl.opd_use  = ctrl_pkg::OPD_USE_RS;
                ctl.hilo_src = ctrl_pkg::HILO_SRC_RS;
                ctl.write_lo = 1'b1;
            end

            isa_pkg::FN_MULT, isa_pkg::FN_MULTU,
            isa_pkg::FN_DIV, isa_pkg::FN_DIVU: begin
                ctl.opd_use  = ctrl_pkg::OPD_USE_RS_RT;
                ctl.hilo_src = ctrl_pkg::HILO_SRC_MULDIV; // Result lands in both HI and LO
                ctl.write_hi = 1'b1;
                ctl.write_lo = 1'b1;
                case (funct)
                    isa_pkg::FN_MULT:  ctl.muldiv_funct = ctrl_pkg::MULDIV_MULT;
                    isa_pkg::FN_MULTU: ctl.muldiv_funct = ctrl_pkg::MULDIV_MULTU;
                    isa_pkg::FN_DIV:   ctl.muldiv_funct = ctrl_pkg::MULDIV_DIV;
                    default:           ctl.muldiv_funct = ctrl_pkg::MULDIV_DIVU;
                endcase
            end

            isa_pkg::FN_SYSCALL: begin
                ctl.opd_use = ctrl_pkg::OPD_USE_NONE;
                ctl.pc_src  = ctrl_pkg::PC_SRC_EXCEPTION;
                ctl.exc_chk = ctrl_pkg::EXC_SYSCALL;
            end

            default: begin
                // Unknown funct traps as a reserved instruction
                ctl.opd_use = ctrl_pkg::OPD_USE_NONE;
                ctl.pc_src  = ctrl_pkg::PC_SRC_EXCEPTION;
                ctl.exc_chk = ctrl_pkg::EXC_RESERVED;
            end
        endcase
    end

endmodule

// File: rtl/itype_decoder.sv
`timescale 1ns/1ps

module itype_decoder (
    input  isa_pkg::opcode_e   opcode,
    output ctrl_pkg::control_t ctl
);

    // rs op immediate, result into rt
    function automatic ctrl_pkg::control_t imm_alu(
        input ctrl_pkg::alu_op_e  op,
        input ctrl_pkg::imm_ext_e ext
    );
        ctrl_pkg::control_t c;
        c           = ctrl_pkg::default_control();
        c.opd_use   = ctrl_pkg::OPD_USE_RS;
        c.alu_op    = op;
        c.alu_b     = ctrl_pkg::ALU_B_IMM;
        c.imm_ext   = ext;
        c.dest      = ctrl_pkg::DEST_RT;
        c.write_reg = 1'b1;
        c.reg_src   = ctrl_pkg::REG_SRC_ALU;
        return c;
    endfunction

    always_comb begin
        ctl = ctrl_pkg::default_control();

        case (opcode)
            isa_pkg::OP_SPECIAL: ; // Handled by the R-type decoder

            isa_pkg::OP_ADDIU: ctl = imm_alu(ctrl_pkg::ALU_ADD, ctrl_pkg::IMM_EXT_SIGN);
            isa_pkg::OP_ORI:   ctl = imm_alu(ctrl_pkg::ALU_OR, ctrl_pkg::IMM_EXT_ZERO);

            isa_pkg::OP_LUI: begin
                ctl         = imm_alu(ctrl_pkg::ALU_PASS_B, ctrl_pkg::IMM_EXT_UPPER);
                ctl.opd_use = ctrl_pkg::OPD_USE_NONE; // rs field is unused
            end

            isa_pkg::OP_LW: begin
                ctl          = imm_alu(ctrl_pkg::ALU_ADD, ctrl_pkg::IMM_EXT_SIGN);
                ctl.mem_read = 1'b1;
                ctl.reg_src  = ctrl_pkg::REG_SRC_MEM;
            end

            isa_pkg::OP_SW: begin
                ctl           = imm_alu(ctrl_pkg::ALU_ADD, ctrl_pkg::IMM_EXT_SIGN);
                ctl.opd_use   = ctrl_pkg::OPD_USE_RS_RT; // rt is the store data
                ctl.write_reg = 1'b0;
                ctl.mem_write = 1'b1;
            end

            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                ctl.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                ctl.imm_ext = ctrl_pkg::IMM_EXT_SIGN;
                ctl.pc_src  = (opcode == isa_pkg::OP_BEQ) ? ctrl_pkg::PC_SRC_BRANCH_EQ
                                                         : ctrl_pkg::PC_SRC_BRANCH_NE;
            end

            isa_pkg::OP_J: ctl.pc_src = ctrl_pkg::PC_SRC_JUMP;

            isa_pkg::OP_JAL: begin
                ctl.pc_src    = ctrl_pkg::PC_SRC_JUMP;
                ctl.dest      = ctrl_pkg::DEST_R31; // Link register
                ctl.write_reg = 1'b1;
                ctl.reg_src   = ctrl_pkg::REG_SRC_PC8;
            end

            default: begin
                ctl.pc_src  = ctrl_pkg::PC_SRC_EXCEPTION;
                ctl.exc_chk = ctrl_pkg::EXC_RESERVED;
            end
        endcase
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module instr_decoder (
    input  isa_pkg::fetch_t    fetch,
    output ctrl_pkg::decoded_t decoded
);

    localparam int PAD_W = `DECODE_XLEN - 16;

    isa_pkg::fields_t   fields;
    ctrl_pkg::control_t r_ctl;
    ctrl_pkg::control_t i_ctl;
    ctrl_pkg::control_t ctl;
    logic [15:0]        imm16;

    assign fields = isa_pkg::fields_t'(fetch.instr);
    assign imm16  = fetch.instr[15:0];

    rtype_decoder rtype_decoder_inst (
        .funct (fields.funct),
        .ctl   (r_ctl)
    );

    itype_decoder itype_decoder_inst (
        .opcode (fields.opcode),
        .ctl    (i_ctl)
    );

    always_comb begin
        if (!fetch.valid)
            ctl = ctrl_pkg::default_control(); // Empty slot does nothing
        else if (fields.opcode == isa_pkg::OP_SPECIAL)
            ctl = r_ctl;
        else
            ctl = i_ctl;
    end

    always_comb begin
        decoded.valid      = fetch.valid;
        decoded.pc         = fetch.pc;
        decoded.ctl        = ctl;
        decoded.rs         = fields.rs;
        decoded.rt         = fields.rt;
        decoded.rd         = fields.rd;
        decoded.shamt      = fields.shamt;
        decoded.jump_index = fetch.instr[25:0];

        case (ctl.imm_ext)
            ctrl_pkg::IMM_EXT_ZERO:  decoded.imm = {{PAD_W{1'b0}}, imm16};
            ctrl_pkg::IMM_EXT_UPPER: decoded.imm = {imm16, {PAD_W{1'b0}}}; // LUI
            default:                 decoded.imm = {{PAD_W{imm16[15]}}, imm16};
        endcase
    end

endmodule

// File: rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // Clear beats hold, hold beats load
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            q <= '0; // All-zero payload has valid low and a no-op bundle
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  isa_pkg::fetch_t    fetch_in,
    output ctrl_pkg::decoded_t id_ex_out
);

    isa_pkg::fetch_t    if_id;
    ctrl_pkg::decoded_t decoded;

    // IF/ID keeps its instruction on stall, drops it on flush
    stage_reg #(
        .payload_t (isa_pkg::fetch_t)
    ) if_id_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (stall),
        .clear (flush),
        .d     (fetch_in),
        .q     (if_id)
    );

    instr_decoder instr_decoder_inst (
        .fetch   (if_id),
        .decoded (decoded)
    );

    // Stall turns the ID/EX slot into a bubble
    stage_reg #(
        .payload_t (ctrl_pkg::decoded_t)
    ) id_ex_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .clear (stall),
        .d     (decoded),
        .q     (id_ex_out)
    );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: dv/decode_tb.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_tb;

    localparam int RESULT_TIMEOUT = 8;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               flush;
    isa_pkg::fetch_t    fetch_in;
    ctrl_pkg::decoded_t id_ex_out;

    tb_clock clock_gen (.clk(clk));

    decode_stage decode_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .fetch_in  (fetch_in),
        .id_ex_out (id_ex_out)
    );

    task automatic stop_with_error(input string what);
        $display("Errors found");
        $fatal(1, "%s", what);
    endtask

    task automatic check_control(input string name, input ctrl_pkg::control_t got,
                                 input ctrl_pkg::control_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("control bundle differs");
        end
    endtask

    task automatic check_decoded(input string name, input ctrl_pkg::decoded_t got,
                                 input ctrl_pkg::decoded_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("decoded payload differs");
        end
    endtask

    task automatic check_valid(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0b expected=%0b", $time, name, got, exp);
            stop_with_error("valid bit differs");
        end
    endtask

    // No-op bundle written out field by field
    function automatic ctrl_pkg::control_t idle_control();
        ctrl_pkg::control_t c;
        c.opd_use      = ctrl_pkg::OPD_USE_NONE;
        c.alu_op       = ctrl_pkg::ALU_ADD;
        c.alu_b        = ctrl_pkg::ALU_B_REG;
        c.dest         = ctrl_pkg::DEST_RD;
        c.write_reg    = 1'b0;
        c.reg_src      = ctrl_pkg::REG_SRC_ALU;
        c.hilo_src     = ctrl_pkg::HILO_SRC_RS;
        c.write_hi     = 1'b0;
        c.write_lo     = 1'b0;
        c.muldiv_funct = ctrl_pkg::MULDIV_NCARE;
        c.pc_src       = ctrl_pkg::PC_SRC_SEQ;
        c.exc_chk      = ctrl_pkg::EXC_NONE;
        c.mem_read     = 1'b0;
        c.mem_write    = 1'b0;
        c.imm_ext      = ctrl_pkg::IMM_EXT_SIGN;
        return c;
    endfunction

    function automatic ctrl_pkg::control_t expected_control(input logic [31:0] instr);
        ctrl_pkg::control_t c;
        c = idle_control();
        if (instr[31:26] == 6'h00) begin
            case (instr[5:0])
                6'h21: begin // ADDU
                    c.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                    c.write_reg = 1'b1;
                end
                6'h00: begin // SLL
                    c.opd_use = ctrl_pkg::OPD_USE_RT;
                    c.alu_op = ctrl_pkg::ALU_SHIFT_LEFT;
                    c.write_reg = 1'b1;
                end
                6'h08: begin
                    c.opd_use = ctrl_pkg::OPD_USE_RS;
                    c.pc_src = ctrl_pkg::PC_SRC_JUMP_REG;
                end
                6'h10, 6'h12: begin // MFHI, MFLO
                    c.write_reg = 1'b1;
                    c.reg_src = (instr[1]) ? ctrl_pkg::REG_SRC_LO : ctrl_pkg::REG_SRC_HI;
                end
                6'h11, 6'h13: begin // MTHI, MTLO
                    c.opd_use = ctrl_pkg::OPD_USE_RS;
                    c.write_hi = !instr[1];
                    c.write_lo = instr[1];
                end
                6'h18, 6'h19, 6'h1a, 6'h1b: begin
                    c.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                    c.hilo_src = ctrl_pkg::HILO_SRC_MULDIV;
                    c.write_hi = 1'b1;
                    c.write_lo = 1'b1;
                    c.muldiv_funct = ctrl_pkg::muldiv_e'({1'b0, instr[1:0]} + 3'd1);
                end
                6'h0c: begin
                    c.pc_src = ctrl_pkg::PC_SRC_EXCEPTION;
                    c.exc_chk = ctrl_pkg::EXC_SYSCALL;
                end
                default: begin
                    c.pc_src = ctrl_pkg::PC_SRC_EXCEPTION;
                    c.exc_chk = ctrl_pkg::EXC_RESERVED;
                end
            endcase
        end else begin
            case (instr[31:26])
                6'h09, 6'h0d, 6'h0f, 6'h23, 6'h2b: begin // Immediate ALU and memory
                    c.opd_use = ctrl_pkg::OPD_USE_RS;
                    c.alu_b = ctrl_pkg::ALU_B_IMM;
                    c.dest = ctrl_pkg::DEST_RT;
                    c.write_reg = 1'b1;
                    if (instr[31:26] == 6'h0d) begin
                        c.alu_op = ctrl_pkg::ALU_OR;
                        c.imm_ext = ctrl_pkg::IMM_EXT_ZERO;
                    end
                    if (instr[31:26] == 6'h0f) begin
                        c.opd_use = ctrl_pkg::OPD_USE_NONE;
                        c.alu_op = ctrl_pkg::ALU_PASS_B;
                        c.imm_ext = ctrl_pkg::IMM_EXT_UPPER;
                    end
                    if (instr[31:26] == 6'h23) begin
                        c.mem_read = 1'b1;
                        c.reg_src = ctrl_pkg::REG_SRC_MEM;
                    end
                    if (instr[31:26] == 6'h2b) begin
                        c.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                        c.write_reg = 1'b0;
                        c.mem_write = 1'b1;
                    end
                end
                6'h04, 6'h05: begin
                    c.opd_use = ctrl_pkg::OPD_USE_RS_RT;
                    c.pc_src = (instr[26]) ? ctrl_pkg::PC_SRC_BRANCH_NE
                                           : ctrl_pkg::PC_SRC_BRANCH_EQ;
                end
                6'h02: c.pc_src = ctrl_pkg::PC_SRC_JUMP;
                6'h03: begin // JAL links through r31
                    c.pc_src = ctrl_pkg::PC_SRC_JUMP;
                    c.dest = ctrl_pkg::DEST_R31;
                    c.write_reg = 1'b1;
                    c.reg_src = ctrl_pkg::REG_SRC_PC8;
                end
                default: begin
                    c.pc_src = ctrl_pkg::PC_SRC_EXCEPTION;
                    c.exc_chk = ctrl_pkg::EXC_RESERVED;
                end
            endcase
        end
        return c;
    endfunction

    function automatic ctrl_pkg::decoded_t expected_decode(input isa_pkg::fetch_t f);
        ctrl_pkg::decoded_t e;
        e.valid = f.valid;
        e.pc = f.pc;
        e.ctl = f.valid ? expected_control(f.instr) : idle_control();
        e.rs = f.instr[25:21];
        e.rt = f.instr[20:16];
        e.rd = f.instr[15:11];
        e.shamt = f.instr[10:6];
        e.jump_index = f.instr[25:0];
        case (e.ctl.imm_ext)
            ctrl_pkg::IMM_EXT_ZERO:  e.imm = {16'h0000, f.instr[15:0]};
            ctrl_pkg::IMM_EXT_UPPER: e.imm = {f.instr[15:0], 16'h0000};
            default:                 e.imm = {{16{f.instr[15]}}, f.instr[15:0]};
        endcase
        return e;
    endfunction

    function automatic isa_pkg::fetch_t make_fetch(input logic [5:0] op, input logic [5:0] fn);
        isa_pkg::fetch_t f;
        f.valid = 1'b1;
        f.pc = {$urandom} & 32'hffff_fffc;
        f.instr = {op, 20'($urandom), fn};
        return f;
    endfunction

    task automatic drive_idle();
        fetch_in = '0;
    endtask

    // Waits for a valid slot and returns the number of rising edges taken
    task automatic wait_result(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!id_ex_out.valid && cycles < RESULT_TIMEOUT);
        if (!id_ex_out.valid)
            stop_with_error("timeout waiting for a valid ID/EX slot");
    endtask

    task automatic decode_one(input string name, input isa_pkg::fetch_t f);
        int cycles;
        @(negedge clk);
        fetch_in = f;
        @(negedge clk);
        drive_idle();
        check_valid({name, " early valid"}, id_ex_out.valid, 1'b0);
        wait_result(cycles);
        if (cycles != 1)
            stop_with_error("instruction took the wrong number of cycles");
        check_control({name, " ctl"}, id_ex_out.ctl, expected_control(f.instr));
        check_decoded({name, " id_ex_out"}, id_ex_out, expected_decode(f));
    endtask

    task automatic test_reset_state();
        isa_pkg::fetch_t cleared;
        cleared = '0;
        cleared.pc = `DECODE_RESET_PC;
        check_valid("reset valid", id_ex_out.valid, 1'b0);
        check_control("reset ctl", id_ex_out.ctl, idle_control());
        @(negedge clk);
        check_decoded("reset IF/ID drained", id_ex_out, expected_decode(cleared));
    endtask

    task automatic test_rtype();
        logic [5:0] functs[$] = '{6'h21, 6'h00, 6'h08, 6'h0c, 6'h10, 6'h11,
                                  6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h3f};
        foreach (functs[i])
            decode_one($sformatf("funct %h", functs[i]), make_fetch(6'h00, functs[i]));
    endtask

    task automatic test_itype();
        logic [5:0] ops[$] = '{6'h09, 6'h0d, 6'h0f, 6'h23, 6'h2b, 6'h04,
                               6'h05, 6'h02, 6'h03, 6'h3f};
        foreach (ops[i])
            decode_one($sformatf("opcode %h", ops[i]), make_fetch(ops[i], 6'($urandom)));
    endtask

    task automatic test_stream();
        isa_pkg::fetch_t sent[$];
        isa_pkg::fetch_t f;
        for (int i = 0; i < 22; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                f = sent.pop_front();
                check_decoded("stream id_ex_out", id_ex_out, expected_decode(f));
            end
            if (i < 20) begin
                f.valid = 1'b1;
                f.pc = 32'h0040_0000 + 32'(i * 4);
                f.instr = $urandom;
                fetch_in = f;
                sent.push_back(f);
            end else begin
                drive_idle();
            end
        end
    endtask

    task automatic test_stall(input int k);
        isa_pkg::fetch_t f;
        int cycles;
        f = make_fetch(6'h09, 6'h00);
        @(negedge clk);
        fetch_in = f;
        @(negedge clk);
        drive_idle();
        stall = 1'b1;
        for (int i = 0; i < k; i++) begin
            @(negedge clk);
            check_valid("stall bubble", id_ex_out.valid, 1'b0);
            check_control("stall bubble ctl", id_ex_out.ctl, idle_control());
        end
        stall = 1'b0;
        wait_result(cycles);
        if (cycles != 1)
            stop_with_error("held instruction did not leave right after the stall");
        check_decoded("after stall", id_ex_out, expected_decode(f));
        @(negedge clk);
        check_valid("held instruction repeated", id_ex_out.valid, 1'b0);
    endtask

    task automatic test_flush();
        isa_pkg::fetch_t f;
        isa_pkg::fetch_t g;
        f = make_fetch(6'h23, 6'h00);
        g = make_fetch(6'h00, 6'h21);
        @(negedge clk);
        fetch_in = f;
        flush = 1'b1; // Discards f as it lands in IF/ID
        @(negedge clk);
        flush = 1'b0;
        fetch_in = g;
        @(negedge clk);
        drive_idle();
        check_valid("flushed slot", id_ex_out.valid, 1'b0);
        check_control("flushed slot ctl", id_ex_out.ctl, idle_control());
        @(negedge clk);
        check_decoded("after flush", id_ex_out, expected_decode(g));
    endtask

    initial begin
        #200us;
        $display("Errors found");
        $fatal(1, "simulation ran past its time limit");
    end

    initial begin
        void'($urandom(32'h748bbd24));
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        fetch_in = make_fetch(6'h09, 6'h00); // Valid fetch offered while in reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        drive_idle();
        test_reset_state();
        test_rtype();
        test_itype();
        test_stream();
        test_stall(1);
        test_stall(3);
        test_flush();
        $display("No errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/rtype_decoder.sv
rtl/itype_decoder.sv
rtl/instr_decoder.sv
rtl/stage_reg.sv
rtl/decode_stage.sv
dv/tb_clock.sv
dv/decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "^No errors$" "$LOG"; then
    if [ $sim_status -ne 0 ]; then
        echo "Simulator returned status $sim_status"
        exit 1
    fi
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
